// File: tb/system_trace.txt
// we addr wdata strb | exp_rdata exp_err exp_wake exp_eoc, all hex
// we is 0 for a read, 1 for a write, 2 ends the trace
1 80000000 11111111 f 00000000 0 00 0
1 80000004 22222222 f 00000000 0 00 0
1 80000008 33333333 f 00000000 0 00 0
1 8000000c 44444444 f 00000000 0 00 0
0 80000000 00000000 0 11111111 0 00 0
0 80000004 00000000 0 22222222 0 00 0
0 80000008 00000000 0 33333333 0 00 0
0 8000000c 00000000 0 44444444 0 00 0
1 80000ff0 aabbccdd f 00000000 0 00 0
1 80000ff0 11223344 5 00000000 0 00 0
0 80000ff0 00000000 0 aa22cc44 0 00 0
1 800007fc deadbeef a 00000000 0 00 0
0 800007fc 00000000 0 de00be00 0 00 0
0 a0000000 00000000 0 80000000 0 00 0
0 a0000004 00000000 0 00000013 0 00 0
0 a000003c 00000000 0 00000013 0 00 0
0 a0000040 00000000 0 00000000 0 00 0
1 a0000004 12345678 f 00000000 1 00 0
0 40000008 00000000 0 00000000 0 00 0
0 4000000c 00000000 0 00010000 0 00 0
0 40000010 00000000 0 00000008 0 00 0
1 4000000c ffffffff f 00000000 1 00 0
1 40000004 000000a5 f 00000000 0 a5 0
0 40000004 00000000 0 00000000 0 00 0
1 40000000 00000001 f 00000000 0 00 1
0 40000000 00000000 0 00000001 0 00 1
0 00000000 00000000 0 00000000 1 00 1
0 80001000 00000000 0 00000000 1 00 1
1 c0000000 00000055 f 00000000 1 00 1
2 00000000 00000000 0 00000000 0 00 0

// File: vlog.f
hw/mempool_pkg.sv
hw/mem_bus_pkg.sv
hw/soc_demux.sv
hw/l2_mem.sv
hw/bootrom.sv
hw/ctrl_registers.sv
hw/mempool_system.sv
tb/mempool_system_sva.sv
tb/mempool_system_tb.sv

// File: Makefile
# Verilator build for the MemPool system testbench

VERILATOR ?= verilator
TOP       := mempool_system_tb
FILELIST  := vlog.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# A $fatal or a failed assertion gives a non-zero exit status
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/mempool_system_tb.sv
// MemPool system testbench
// Replays the operation trace on the host port and checks responses and side outputs
`default_nettype none
`timescale 1ns/100ps

module mempool_system_tb;

  localparam int NumFields = 8;   // Columns per trace line
  localparam int MaxOps    = 64;
  localparam int BurstLen  = 8;   // Leading ops sent with no idle cycles

  logic                             clk_i;
  logic                             rst_n_i;
  mem_bus_pkg::sys_req_t            host_req_i;
  mem_bus_pkg::sys_rsp_t            host_rsp_o;
  logic [mempool_pkg::NumCores-1:0] wake_up_o;
  logic                             eoc_valid_o;

  logic [31:0] trace_mem [MaxOps*NumFields];
  int          req_cyc [MaxOps];  // Cycle in which each request was seen on the port
  int          rsp_q[$];
  int          side_q[$];
  int          num_ops;
  int          req_seen = 0;
  int          cyc = 0;
  int          cycle_limit = 0;
  integer      seed = 32'hb5563e7f;

  mempool_system DUT (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .host_req_i (host_req_i ),
    .host_rsp_o (host_rsp_o ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic mem_bus_pkg::sys_req_t op_request(int idx);
    int b;
    b = idx * NumFields;
    return '{valid: 1'b1, we: trace_mem[b][0], addr: trace_mem[b+1],
             wdata: trace_mem[b+2], strb: trace_mem[b+3][mempool_pkg::StrbWidth-1:0]};
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Cycle count and run limit
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cycle_limit > 0 && cyc >= cycle_limit) begin
      abort_run("Timeout: the trace did not complete within the cycle limit");
    end
  end

  // Outputs are sampled at the falling edge, half a cycle after they settle
  always @(negedge clk_i) begin : check_outputs
    int idx;
    if (side_q.size() != 0 && req_cyc[side_q[0]] + 1 == cyc) begin
      idx = side_q.pop_front();
      check_value($sformatf("op %0d wake_up_o", idx), 32'(wake_up_o),
                  trace_mem[idx*NumFields+6]);
      check_value($sformatf("op %0d eoc_valid_o", idx), 32'(eoc_valid_o),
                  trace_mem[idx*NumFields+7]);
    end
    if (host_rsp_o.valid) begin
      if (rsp_q.size() == 0) begin
        abort_run("Response valid arrived with no request outstanding");
      end
      idx = rsp_q.pop_front();
      check_value($sformatf("op %0d response cycle", idx), cyc, req_cyc[idx] + 2);
      check_value($sformatf("op %0d rdata", idx), host_rsp_o.rdata, trace_mem[idx*NumFields+4]);
      check_value($sformatf("op %0d err", idx), 32'(host_rsp_o.err), trace_mem[idx*NumFields+5]);
    end
    if (host_req_i.valid) begin
      req_cyc[req_seen] = cyc;
      rsp_q.push_back(req_seen);
      side_q.push_back(req_seen);
      req_seen++;
    end
  end

  initial begin : drive_trace
    int gap;
    host_req_i = '0;
    rst_n_i    = 1'b0;
    $readmemh("tb/system_trace.txt", trace_mem);
    num_ops = 0;
    while (num_ops < MaxOps && trace_mem[num_ops*NumFields] != 32'd2) begin
      num_ops++;
    end
    if (num_ops == 0 || num_ops == MaxOps) begin
      abort_run("Trace file is missing, empty or has no end line");
    end
    cycle_limit = num_ops * 4 + 100;

    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    for (int i = 0; i < num_ops; i++) begin
      @(posedge clk_i);
      host_req_i <= op_request(i);
      if (i >= BurstLen) begin
        gap = $unsigned($random(seed)) % 3; // Idle cycles after this request
        repeat (gap) begin
          @(posedge clk_i);
          host_req_i.valid <= 1'b0;
        end
      end
    end
    @(posedge clk_i);
    host_req_i.valid <= 1'b0;

    // Every response and side output check has been seen once both queues drain
    while (rsp_q.size() != 0 || side_q.size() != 0) begin
      @(posedge clk_i);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule : mempool_system_tb

`default_nettype wire

// File: tb/mempool_system_sva.sv
// Host port protocol assertions for the MemPool system
// Reset quiet, fixed response latency and single-cycle wake-up pulses
`default_nettype none
`timescale 1ns/100ps

module mempool_system_sva (
  input logic                             clk_i,
  input logic                             rst_n_i,
  input mem_bus_pkg::sys_req_t            host_req_i,
  input mem_bus_pkg::sys_rsp_t            host_rsp_i,
  input logic [mempool_pkg::NumCores-1:0] wake_up_i
);

  // Held in reset for a second edge, response valid is already cleared
  rsp_quiet_in_reset: assert property (@(posedge clk_i)
    (!rst_n_i && $past(!rst_n_i)) |-> !host_rsp_i.valid)
    else $error("Response valid while in reset");

  // Response valid exactly two edges after the accepting edge, in both directions
  rsp_two_cycle_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rsp_i.valid == $past(host_req_i.valid, 2))
    else $error("Response valid does not line up with a request two cycles earlier");

  wake_up_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|wake_up_i) |=> !(|wake_up_i))
    else $error("wake_up_o high for two cycles in a row");

endmodule : mempool_system_sva

bind mempool_system mempool_system_sva i_mempool_system_sva (
  .clk_i     (clk_i     ),
  .rst_n_i   (rst_n_i   ),
  .host_req_i(host_req_i),
  .host_rsp_i(host_rsp_o),
  .wake_up_i (wake_up_o )
);

`default_nettype wire

// File: hw/mempool_system.sv
// MemPool system top level
// Host port through the address demultiplexer to L2, boot ROM and control registers
`default_nettype none
`timescale 1ns/100ps

module mempool_system (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  mem_bus_pkg::sys_req_t            host_req_i,
  output mem_bus_pkg::sys_rsp_t            host_rsp_o,
  output logic [mempool_pkg::NumCores-1:0] wake_up_o,
  output logic                             eoc_valid_o
);

  mem_bus_pkg::tgt_req_t l2_req;
  mem_bus_pkg::tgt_req_t rom_req;
  mem_bus_pkg::tgt_req_t ctrl_req;
  mem_bus_pkg::tgt_rsp_t l2_rsp;
  mem_bus_pkg::tgt_rsp_t rom_rsp;
  mem_bus_pkg::tgt_rsp_t ctrl_rsp;

  soc_demux i_soc_demux (
    .clk_i     (clk_i     ),
    .rst_n_i   (rst_n_i   ),
    .host_req_i(host_req_i),
    .host_rsp_o(host_rsp_o),
    .l2_req_o  (l2_req    ),
    .rom_req_o (rom_req   ),
    .ctrl_req_o(ctrl_req  ),
    .l2_rsp_i  (l2_rsp    ),
    .rom_rsp_i (rom_rsp   ),
    .ctrl_rsp_i(ctrl_rsp  )
  );

  l2_mem i_l2_mem (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .req_i  (l2_req ),
    .rsp_o  (l2_rsp )
  );

  bootrom i_bootrom (
    .clk_i(clk_i  ),
    .req_i(rom_req),
    .rsp_o(rom_rsp)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (ctrl_req   ),
    .rsp_o      (ctrl_rsp   ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : mempool_system

`default_nettype wire

// File: hw/ctrl_registers.sv
// Control registers
// End of computation, per-core wake-up pulse and read-only system information
`default_nettype none
`timescale 1ns/100ps

module ctrl_registers (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  mem_bus_pkg::tgt_req_t            req_i,
  output mem_bus_pkg::tgt_rsp_t            rsp_o,
  output logic [mempool_pkg::NumCores-1:0] wake_up_o,
  output logic                             eoc_valid_o
);

  mem_bus_pkg::addr_t               reg_off;
  logic                             wr;
  logic                             eoc_we;
  logic                             wake_we;
  logic                             err_d;
  mem_bus_pkg::data_t               rdata_d;
  mem_bus_pkg::data_t               eoc_q;
  logic [mempool_pkg::NumCores-1:0] wake_up_q;
  mem_bus_pkg::data_t               rdata_q;
  logic                             err_q;

  assign reg_off = mem_bus_pkg::addr_t'(req_i.addr.region.offset);
  assign wr      = req_i.req && req_i.we;

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    eoc_we  = 1'b0;
    wake_we = 1'b0;
    unique case (reg_off)
      mempool_pkg::EocOffset: begin
        rdata_d = eoc_q;
        eoc_we  = wr;
      end
      mempool_pkg::WakeUpOffset: begin
        wake_we = wr; // Reads as zero
      end
      mempool_pkg::TcdmStartOffset: begin
        rdata_d = mempool_pkg::TcdmBaseAddr;
        err_d   = req_i.we;
      end
      mempool_pkg::TcdmEndOffset: begin
        rdata_d = mempool_pkg::TcdmBaseAddr + mempool_pkg::TcdmSize;
        err_d   = req_i.we;
      end
      mempool_pkg::NumCoresOffset: begin
        rdata_d = mem_bus_pkg::data_t'(mempool_pkg::NumCores);
        err_d   = req_i.we;
      end
      default: err_d = 1'b1; // No register here
    endcase
    if (req_i.we) begin
      rdata_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q     <= '0;
      wake_up_q <= '0;
    end else begin
      if (eoc_we) begin
        eoc_q <= req_i.wdata;
      end
      // Single-cycle pulse of the written mask
      wake_up_q <= wake_we ? req_i.wdata[mempool_pkg::NumCores-1:0] : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign rsp_o       = '{rdata: rdata_q, err: err_q};
  assign wake_up_o   = wake_up_q;
  assign eoc_valid_o = eoc_q[0];

endmodule : ctrl_registers

`default_nettype wire

// File: hw/bootrom.sv
// Boot ROM
// Fixed boot table, word 0 points at L2, writes are rejected
`default_nettype none
`timescale 1ns/100ps

module bootrom (
  input  logic                  clk_i,
  input  mem_bus_pkg::tgt_req_t req_i,
  output mem_bus_pkg::tgt_rsp_t rsp_o
);

  mem_bus_pkg::addr_t word_idx;
  mem_bus_pkg::data_t rom_word;
  mem_bus_pkg::data_t rdata_q;
  logic               err_q;

  assign word_idx = mem_bus_pkg::addr_t'(req_i.addr.region.offset) >> mempool_pkg::ByteOffWidth;

  always_comb begin
    if (word_idx == '0) begin
      rom_word = mempool_pkg::L2MemoryBaseAddr; // Boot address
    end else if (word_idx < mempool_pkg::BootromNumWords) begin
      rom_word = mempool_pkg::BootromFill;
    end else begin
      rom_word = '0;                            // Past the table
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rom_word;
      err_q   <= req_i.we;
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q};

endmodule : bootrom

`default_nettype wire

// File: hw/l2_mem.sv
// Banked L2 memory
// Word-interleaved banks with byte strobes and a one-cycle read
`default_nettype none
`timescale 1ns/100ps

module l2_mem (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_bus_pkg::tgt_req_t req_i,
  output mem_bus_pkg::tgt_rsp_t rsp_o
);

  logic [mempool_pkg::NumL2Banks-1:0]      bank_sel;
  mem_bus_pkg::data_t [mempool_pkg::NumL2Banks-1:0] bank_rdata;
  mem_bus_pkg::data_t                      rdata_q;

  // One-hot bank select from the interleave bits
  always_comb begin
    bank_sel = '0;
    bank_sel[req_i.addr.l2.bank] = 1'b1;
  end

  for (genvar b = 0; b < mempool_pkg::NumL2Banks; b++) begin : gen_banks
    mem_bus_pkg::data_t [mempool_pkg::L2BankNumWords-1:0] words_q;
    logic                                                 bank_we;

    assign bank_we = req_i.req && req_i.we && bank_sel[b];

    // Cleared on reset in this model
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        words_q <= '0;
      end else if (bank_we) begin
        for (int unsigned i = 0; i < mempool_pkg::StrbWidth; i++) begin
          if (req_i.strb[i]) begin
            words_q[req_i.addr.l2.row][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end
    end

    assign bank_rdata[b] = words_q[req_i.addr.l2.row]; // Old word on a write cycle
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : bank_rdata[req_i.addr.l2.bank];
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: 1'b0}; // L2 never faults

endmodule : l2_mem

`default_nettype wire

// File: hw/soc_demux.sv
// SoC address demultiplexer
// Routes host requests to L2, boot ROM or control registers and returns responses in order
`default_nettype none
`timescale 1ns/100ps

module soc_demux (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_bus_pkg::sys_req_t host_req_i,
  output mem_bus_pkg::sys_rsp_t host_rsp_o,
  output mem_bus_pkg::tgt_req_t l2_req_o,
  output mem_bus_pkg::tgt_req_t rom_req_o,
  output mem_bus_pkg::tgt_req_t ctrl_req_o,
  input  mem_bus_pkg::tgt_rsp_t l2_rsp_i,
  input  mem_bus_pkg::tgt_rsp_t rom_rsp_i,
  input  mem_bus_pkg::tgt_rsp_t ctrl_rsp_i
);

  mem_bus_pkg::sys_addr_u addr_u;
  mem_bus_pkg::target_e   tgt_sel;
  mem_bus_pkg::target_e   tgt_q;
  mem_bus_pkg::tgt_req_t  tgt_req;
  mem_bus_pkg::tgt_rsp_t  rsp_sel;
  logic                   valid_q;
  logic                   rsp_valid_q;
  logic                   rsp_err_q;
  mem_bus_pkg::data_t     rsp_rdata_q;

  // Hit when the region matches and the offset lies below the window size
  function automatic logic in_window(mem_bus_pkg::sys_addr_u a, mem_bus_pkg::addr_t base,
                                     mem_bus_pkg::addr_t limit);
    mem_bus_pkg::sys_addr_u b;
    b = base;
    return (a.region.region == b.region.region) &&
           (mem_bus_pkg::addr_t'(a.region.offset) < (limit - base));
  endfunction

  assign addr_u = host_req_i.addr;

  always_comb begin
    tgt_sel = mem_bus_pkg::TgtNone;
    if (in_window(addr_u, mempool_pkg::L2MemoryBaseAddr, mempool_pkg::L2MemoryEndAddr)) begin
      tgt_sel = mem_bus_pkg::TgtL2;
    end else if (in_window(addr_u, mempool_pkg::BootromBaseAddr,
                           mempool_pkg::BootromEndAddr)) begin
      tgt_sel = mem_bus_pkg::TgtBootrom;
    end else if (in_window(addr_u, mempool_pkg::CtrlRegistersBaseAddr,
                           mempool_pkg::CtrlRegistersEndAddr)) begin
      tgt_sel = mem_bus_pkg::TgtCtrl;
    end
  end

  // Payload is broadcast, only the selected target sees req
  always_comb begin
    tgt_req = '{req: 1'b0, we: host_req_i.we, addr: addr_u,
                wdata: host_req_i.wdata, strb: host_req_i.strb};
    l2_req_o       = tgt_req;
    rom_req_o      = tgt_req;
    ctrl_req_o     = tgt_req;
    l2_req_o.req   = host_req_i.valid && (tgt_sel == mem_bus_pkg::TgtL2);
    rom_req_o.req  = host_req_i.valid && (tgt_sel == mem_bus_pkg::TgtBootrom);
    ctrl_req_o.req = host_req_i.valid && (tgt_sel == mem_bus_pkg::TgtCtrl);
  end

  always_comb begin
    unique case (tgt_q)
      mem_bus_pkg::TgtL2:      rsp_sel = l2_rsp_i;
      mem_bus_pkg::TgtBootrom: rsp_sel = rom_rsp_i;
      mem_bus_pkg::TgtCtrl:    rsp_sel = ctrl_rsp_i;
      default:                 rsp_sel = '{rdata: '0, err: 1'b1}; // Unmapped
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q     <= 1'b0;
      tgt_q       <= mem_bus_pkg::TgtNone;
      rsp_valid_q <= 1'b0;
    end else begin
      valid_q     <= host_req_i.valid; // Stage 1 target in flight
      tgt_q       <= tgt_sel;
      rsp_valid_q <= valid_q;          // Stage 2 response to host
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_q) begin
      rsp_err_q   <= rsp_sel.err;
      rsp_rdata_q <= rsp_sel.rdata;
    end
  end

  assign host_rsp_o = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rsp_rdata_q};

endmodule : soc_demux

`default_nettype wire

// File: hw/mem_bus_pkg.sv
// Memory bus types
// Host and target request/response words, target select and address views
`default_nettype none

package mem_bus_pkg;

  typedef logic [mempool_pkg::AddrWidth-1:0] addr_t;
  typedef logic [mempool_pkg::DataWidth-1:0] data_t;
  typedef logic [mempool_pkg::StrbWidth-1:0] strb_t;

  // Region view used by the address decoder
  typedef struct packed {
    logic [mempool_pkg::RegionWidth-1:0]                         region;
    logic [mempool_pkg::AddrWidth-mempool_pkg::RegionWidth-1:0]  offset;
  } region_view_t;

  // Word-interleaved view used by the L2 banks
  typedef struct packed {
    logic [mempool_pkg::AddrWidth-mempool_pkg::L2RowIdxWidth-mempool_pkg::L2BankIdxWidth
           -mempool_pkg::ByteOffWidth-1:0] upper;
    logic [mempool_pkg::L2RowIdxWidth-1:0]  row;
    logic [mempool_pkg::L2BankIdxWidth-1:0] bank;
    logic [mempool_pkg::ByteOffWidth-1:0]   byte_off;
  } l2_view_t;

  typedef union packed {
    region_view_t region;
    l2_view_t     l2;
  } sys_addr_u;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } sys_req_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } sys_rsp_t;

  typedef struct packed {
    logic      req;
    logic      we;
    sys_addr_u addr;
    data_t     wdata;
    strb_t     strb;
  } tgt_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } tgt_rsp_t;

  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

endpackage : mem_bus_pkg

`default_nettype wire

// File: hw/mempool_pkg.sv
// MemPool system configuration
// Core count, L2 geometry, address map and control register offsets
`default_nettype none

package mempool_pkg;

  localparam int unsigned NumCores     = 8;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned RegionWidth  = 4;                  // Top bits that select a region
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);

  // L2 geometry
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2Size         = NumL2Banks * L2BankNumWords * StrbWidth; // 4 KiB
  localparam int unsigned L2BankIdxWidth = $clog2(NumL2Banks);
  localparam int unsigned L2RowIdxWidth  = $clog2(L2BankNumWords);

  // Address map
  localparam logic [AddrWidth-1:0] L2MemoryBaseAddr      = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] L2MemoryEndAddr       = L2MemoryBaseAddr + L2Size;
  localparam logic [AddrWidth-1:0] CtrlRegistersBaseAddr = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] CtrlRegistersEndAddr  = 32'h4001_0000;
  localparam logic [AddrWidth-1:0] BootromBaseAddr       = 32'hA000_0000;
  localparam logic [AddrWidth-1:0] BootromEndAddr        = 32'hA001_0000;

  // Boot table
  localparam int unsigned          BootromNumWords = 16;
  localparam logic [DataWidth-1:0] BootromFill     = 32'h0000_0013; // nop

  // Control register offsets
  localparam logic [AddrWidth-1:0] EocOffset        = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] WakeUpOffset     = 32'h0000_0004;
  localparam logic [AddrWidth-1:0] TcdmStartOffset  = 32'h0000_0008;
  localparam logic [AddrWidth-1:0] TcdmEndOffset    = 32'h0000_000C;
  localparam logic [AddrWidth-1:0] NumCoresOffset   = 32'h0000_0010;

  // TCDM window reported to software
  localparam logic [AddrWidth-1:0] TcdmBaseAddr = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] TcdmSize     = 32'h0001_0000;

endpackage : mempool_pkg

`default_nettype wire
